//--- build.f
rtl/axi_pkg.sv
rtl/dram_pkg.sv
rtl/axi_slave_port.sv
rtl/dram_ctrl.sv
rtl/dram_subsystem_top.sv
sim/dram_model.sv
sim/dram_properties.sv
sim/tb_dram_subsystem.sv

//--- Makefile
TOP := tb_dram_subsystem

.PHONY: all lint clean

# Build and run, the log decides pass or fail
all:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f build.f
	./obj_dir/V$(TOP) | tee sim.log
	@grep -q "TEST PASSED" sim.log || (echo "simulation failed, see sim.log"; exit 1)

lint:
	verilator --lint-only -Wall --top-module dram_subsystem_top \
		rtl/axi_pkg.sv rtl/dram_pkg.sv rtl/axi_slave_port.sv \
		rtl/dram_ctrl.sv rtl/dram_subsystem_top.sv

clean:
	rm -rf obj_dir sim.log

//--- sim/tb_dram_subsystem.sv
`timescale 1ns/1ns
`default_nettype none

module tb_dram_subsystem
  import axi_pkg::*, dram_pkg::*;
();

  localparam int N_TESTS    = 6;
  localparam int MAX_CYCLES = N_TESTS * 17 * 40;

  logic      clk;
  logic      rstn;
  axi_ax_t   aw;
  axi_ax_t   ar;
  axi_w_t    w;
  axi_r_t    r;
  axi_b_t    b;
  dram_cmd_t cmd;
  dram_rsp_t rsp;
  logic      aw_valid, aw_ready, w_valid, w_ready, ar_valid, ar_ready;
  logic      r_valid, r_ready, b_valid, b_ready;

  integer    seed    = 32'h3e53_26da;
  integer    bp_seed = 32'h3e53_26da;
  int        errors, checks, cycles, test_no, test_errs, failed_tests;
  logic      bp_en;
  axi_data_t wdata [16];
  axi_strb_t wstrb [16];
  // Shadow of every word written so far, keyed by word address
  logic [31:0] shadow [logic [20:0]];
  axi_addr_t exp_addr [$];
  axi_id_t   exp_id [$];
  logic      exp_last [$];
  axi_addr_t cmp_addr;
  axi_id_t   cmp_id;
  logic      cmp_last;

  dram_subsystem_top #(.T_RCD(2), .T_RP(2)) u_dut (.*);
  dram_model #(.CL(3)) u_mem (.*);

  initial begin
    clk = 1'b0;
    forever #50 clk = ~clk;
  end

  function automatic logic [31:0] ref_read(input axi_addr_t addr);
    if (shadow.exists(addr[22:2])) begin
      return shadow[addr[22:2]];
    end
    return {addr[12:2], addr[22:2]};
  endfunction

  function automatic logic [31:0] strb_merge(input logic [31:0] old, input axi_data_t data,
                                             input axi_strb_t strb);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (strb[i]) begin
        res[8*i +: 8] = data[8*i +: 8];
      end
    end
    return res;
  endfunction

  task automatic check(input logic [31:0] got, input logic [31:0] exp, input string what);
    checks++;
    if (got !== exp) begin
      errors++;
      $display("mismatch at %0t ns: %s got %h, expected %h", $time, what, got, exp);
    end
  endtask

  task automatic make_beats(input bit partial);
    for (int i = 0; i < 16; i++) begin
      wdata[i] = $random(seed);
      wstrb[i] = partial ? 4'($random(seed)) : 4'hf;
      if (wstrb[i] == 4'h0) begin
        wstrb[i] = 4'h8;
      end
    end
  endtask

  // Column kept low enough that a 16 beat burst stays in its row
  task automatic pick_addr(output axi_addr_t a);
    dram_row_t row;
    dram_col_t col;
    row = 11'($random(seed));
    col = 10'(($random(seed) & 32'h7fff_ffff) % 1009);
    a   = {9'h0, row, col, 2'b00};
  endtask

  task automatic axi_write(input axi_id_t tid, input axi_addr_t taddr, input axi_len_t tlen);
    axi_addr_t a;
    // Shadow holds the new words before AW is offered
    for (int i = 0; i <= int'(tlen); i++) begin
      a = taddr + 4 * i;
      shadow[a[22:2]] = strb_merge(ref_read(a), wdata[i], wstrb[i]);
    end
    aw       = '{id: tid, addr: taddr, len: tlen};
    aw_valid = 1'b1;
    @(negedge clk);
    while (!aw_ready) @(negedge clk);
    @(posedge clk);
    #1;
    aw_valid = 1'b0;
    for (int i = 0; i <= int'(tlen); i++) begin
      w       = '{data: wdata[i], strb: wstrb[i], last: (i == int'(tlen))};
      w_valid = 1'b1;
      @(negedge clk);
      while (!w_ready) @(negedge clk);
      @(posedge clk);
      #1;
    end
    w_valid = 1'b0;
    b_ready = 1'b1;
    @(negedge clk);
    while (!b_valid) @(negedge clk);
    check(b.id, tid, "bid");
    check(b.resp, axi_resp_okay, "bresp");
    @(posedge clk);
    #1;
    b_ready = 1'b0;
  endtask

  task automatic axi_read(input axi_id_t tid, input axi_addr_t taddr, input axi_len_t tlen);
    for (int i = 0; i <= int'(tlen); i++) begin
      exp_addr.push_back(taddr + 4 * i);
      exp_id.push_back(tid);
      exp_last.push_back(i == int'(tlen));
    end
    ar       = '{id: tid, addr: taddr, len: tlen};
    ar_valid = 1'b1;
    @(negedge clk);
    while (!ar_ready) @(negedge clk);
    @(posedge clk);
    #1;
    ar_valid = 1'b0;
    while (exp_addr.size() != 0) @(posedge clk);
    #1;
  endtask

  task automatic report_test(input string name);
    test_no++;
    if (errors == test_errs) begin
      $display("test %0d %s: ok", test_no, name);
    end else begin
      failed_tests++;
      $display("test %0d %s: %0d errors", test_no, name, errors - test_errs);
    end
    test_errs = errors;
  endtask

  // R beats are compared as they are accepted
  always @(negedge clk) begin
    if (rstn && r_valid && r_ready) begin
      if (exp_addr.size() == 0) begin
        errors++;
        $display("R beat at %0t ns arrived with no read outstanding", $time);
      end else begin
        cmp_addr = exp_addr.pop_front();
        cmp_id   = exp_id.pop_front();
        cmp_last = exp_last.pop_front();
        check(r.data, ref_read(cmp_addr), "rdata");
        check(r.id, cmp_id, "rid");
        check(r.last, cmp_last, "rlast");
        check(r.resp, axi_resp_okay, "rresp");
      end
    end
  end

  initial begin
    r_ready = 1'b0;
    forever begin
      @(posedge clk);
      #1;
      r_ready = bp_en ? 1'($random(bp_seed)) : 1'b1;
    end
  end

  initial begin
    cycles = 0;
    while (cycles < MAX_CYCLES) begin
      @(posedge clk);
      cycles++;
    end
    $display("timeout: run still busy after %0d cycles", MAX_CYCLES);
    $display("TEST FAILED");
    $finish;
  end

  initial begin
    axi_addr_t a;
    axi_addr_t last_wr;
    axi_len_t  len;
    axi_id_t   tid;
    rstn     = 1'b0;
    aw       = '0;
    aw_valid = 1'b0;
    w        = '0;
    w_valid  = 1'b0;
    ar       = '0;
    ar_valid = 1'b0;
    b_ready  = 1'b0;
    bp_en    = 1'b0;
    errors   = 0;
    checks   = 0;
    test_no  = 0;
    test_errs    = 0;
    failed_tests = 0;
    repeat (4) @(posedge clk);
    #1;
    rstn = 1'b1;
    @(posedge clk);
    #1;

    make_beats(1'b0);
    axi_write(4'h3, 32'h0001_2340, 4'd0);
    axi_read(4'h5, 32'h0001_2340, 4'd0);
    report_test("single write then read");

    // Read starts four words early and runs four past the written block
    make_beats(1'b0);
    axi_write(4'h1, 32'h0045_6400, 4'd7);
    axi_read(4'h2, 32'h0045_63f0, 4'd15);
    report_test("8 beat write, 16 beat read");

    make_beats(1'b0);
    axi_write(4'h4, 32'h0007_8800, 4'd3);
    make_beats(1'b1);
    axi_write(4'h4, 32'h0007_8800, 4'd3);
    axi_read(4'h6, 32'h0007_8800, 4'd3);
    report_test("partial strobes");

    bp_en = 1'b1;
    make_beats(1'b0);
    axi_write(4'h7, 32'h0012_3000, 4'd15);
    axi_read(4'h8, 32'h0012_3000, 4'd15);
    bp_en = 1'b0;
    report_test("R back-pressure");

    make_beats(1'b0);
    fork
      axi_write(4'h9, 32'h0000_5a0c, 4'd0);
      axi_read(4'ha, 32'h0000_5a0c, 4'd0);
    join
    report_test("AW and AR together");

    // Half of the reads go back to the last written burst
    bp_en   = 1'b1;
    last_wr = 32'h0012_3000;
    for (int n = 0; n < 30; n++) begin
      pick_addr(a);
      len = 4'($random(seed));
      tid = 4'($random(seed));
      if ($random(seed) & 1) begin
        make_beats(1'b1);
        axi_write(tid, a, len);
        last_wr = a;
      end else begin
        axi_read(tid, ($random(seed) & 1) ? last_wr : a, len);
      end
    end
    bp_en = 1'b0;
    report_test("random traffic");

    $display("%0d tests, %0d failed, %0d checks, %0d errors",
             test_no, failed_tests, checks, errors);
    if (errors == 0) begin
      $display("TEST PASSED");
    end else begin
      $display("TEST FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

//--- sim/dram_properties.sv
`timescale 1ns/1ns
`default_nettype none

module dram_properties
  import axi_pkg::*, dram_pkg::*;
(
  input logic        clk,
  input logic        rstn,
  input dram_cmd_t   cmd,
  input ctrl_state_e state,
  input axi_r_t      r,
  input logic        r_valid,
  input logic        r_ready,
  input axi_b_t      b,
  input logic        b_valid,
  input logic        b_ready
);

  // Any active strobe needs chip select
  a_csn: assert property (@(posedge clk) disable iff (!rstn)
    (!cmd.rasn || !cmd.casn || cmd.wen != 4'hf) |-> !cmd.csn)
    else $error("DRAM strobe driven with csn high");

  a_ras_cas: assert property (@(posedge clk) disable iff (!rstn)
    cmd.rasn || cmd.casn)
    else $error("rasn and casn low in the same cycle");

  a_wen: assert property (@(posedge clk) disable iff (!rstn)
    (state != WRITE) |-> (cmd.wen == 4'hf))
    else $error("wen active outside WRITE");

  a_r_hold: assert property (@(posedge clk) disable iff (!rstn)
    (r_valid && !r_ready) |=> (r_valid && $stable(r)))
    else $error("R beat dropped or changed before its handshake");

  a_b_hold: assert property (@(posedge clk) disable iff (!rstn)
    (b_valid && !b_ready) |=> (b_valid && $stable(b)))
    else $error("B response dropped or changed before its handshake");

endmodule

bind dram_subsystem_top dram_properties u_props (
  .clk    (clk),
  .rstn   (rstn),
  .cmd    (cmd),
  .state  (u_ctrl.state),
  .r      (r),
  .r_valid(r_valid),
  .r_ready(r_ready),
  .b      (b),
  .b_valid(b_valid),
  .b_ready(b_ready)
);

`default_nettype wire

//--- sim/dram_model.sv
`timescale 1ns/1ns
`default_nettype none

module dram_model
  import dram_pkg::*;
#(
  parameter int CL = 3
) (
  input  logic      clk,
  input  logic      rstn,
  input  dram_cmd_t cmd,
  output dram_rsp_t rsp
);

  logic [31:0]   mem [logic [20:0]];
  logic          row_open;
  dram_row_t     open_row;
  logic [20:0]   key;
  logic          rd_start;
  logic [CL-1:0] rd_vld;
  logic [31:0]   rd_q [CL];

  // Unwritten words read back as a function of their word address
  function automatic logic [31:0] fill_word(input logic [20:0] k);
    return {k[10:0], k};
  endfunction

  function automatic logic [31:0] word_at(input logic [20:0] k);
    if (mem.exists(k)) begin
      return mem[k];
    end
    return fill_word(k);
  endfunction

  function automatic logic [31:0] merge_bytes(input logic [31:0] old, input logic [31:0] d,
                                              input logic [3:0] wen);
    logic [31:0] res;
    res = old;
    for (int i = 0; i < 4; i++) begin
      if (!wen[i]) begin
        res[8*i +: 8] = d[8*i +: 8];
      end
    end
    return res;
  endfunction

  assign key      = {open_row, cmd.a[9:0]};
  assign rd_start = !cmd.csn && cmd.rasn && !cmd.casn && (cmd.wen == 4'hf);
  assign rsp      = '{q: rd_q[CL-1], valid: rd_vld[CL-1]};

  always @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      row_open <= 1'b0;
      open_row <= '0;
      rd_vld   <= '0;
    end else begin
      // Read data walks down a CL deep pipe
      rd_vld   <= {rd_vld[CL-2:0], rd_start};
      rd_q[0]  <= word_at(key);
      for (int i = 1; i < CL; i++) begin
        rd_q[i] <= rd_q[i-1];
      end
      if (!cmd.csn && !cmd.rasn && cmd.casn) begin
        row_open <= !row_open;
        if (!row_open) begin
          open_row <= cmd.a;
        end
      end else if (!cmd.csn && cmd.rasn && !cmd.casn && cmd.wen != 4'hf) begin
        mem[key] = merge_bytes(word_at(key), cmd.d, cmd.wen);
      end
    end
  end

endmodule

`default_nettype wire

//--- rtl/dram_subsystem_top.sv
`timescale 1ns/1ns
`default_nettype none

module dram_subsystem_top
  import axi_pkg::*, dram_pkg::*;
#(
  parameter int T_RCD = 2,
  parameter int T_RP  = 2
) (
  input  logic      clk,
  input  logic      rstn,
  input  axi_ax_t   aw,
  input  logic      aw_valid,
  output logic      aw_ready,
  input  axi_w_t    w,
  input  logic      w_valid,
  output logic      w_ready,
  input  axi_ax_t   ar,
  input  logic      ar_valid,
  output logic      ar_ready,
  output axi_r_t    r,
  output logic      r_valid,
  input  logic      r_ready,
  output axi_b_t    b,
  output logic      b_valid,
  input  logic      b_ready,
  output dram_cmd_t cmd,
  input  dram_rsp_t rsp
);

  // Port to controller
  mem_req_t  req;
  logic      req_valid;
  logic      req_ready;
  axi_w_t    wbeat;
  logic      wbeat_valid;
  logic      wbeat_ready;
  axi_data_t rbeat_data;
  logic      rbeat_valid;
  logic      rbeat_ready;
  logic      wr_done;

  axi_slave_port u_port (.*);

  dram_ctrl #(
    .T_RCD(T_RCD),
    .T_RP (T_RP)
  ) u_ctrl (.*);

endmodule

`default_nettype wire

//--- rtl/dram_ctrl.sv
`timescale 1ns/1ns
`default_nettype none

module dram_ctrl
  import axi_pkg::*, dram_pkg::*;
#(
  parameter int T_RCD = 2,
  parameter int T_RP  = 2
) (
  input  logic      clk,
  input  logic      rstn,
  input  mem_req_t  req,
  input  logic      req_valid,
  output logic      req_ready,
  input  axi_w_t    wbeat,
  input  logic      wbeat_valid,
  output logic      wbeat_ready,
  output axi_data_t rbeat_data,
  output logic      rbeat_valid,
  input  logic      rbeat_ready,
  output logic      wr_done,
  output dram_cmd_t cmd,
  input  dram_rsp_t rsp
);

  localparam int T_MAX = (T_RCD > T_RP) ? T_RCD : T_RP;
  localparam int CNT_W = $clog2(T_MAX + 1);

  ctrl_state_e      state;
  ctrl_state_e      state_nxt;
  dram_op_e         op_nxt;
  dram_cmd_t        cmd_nxt;
  logic [CNT_W-1:0] cnt;
  axi_len_t         bcnt;
  dram_col_t        col;
  logic             is_write;
  logic             wr_last;
  logic             wbeat_hs;
  logic             rbeat_hs;

  assign req_ready   = (state == IDLE);
  // One cycle gap after the last beat so its CAS shows up while still in WRITE
  assign wbeat_ready = (state == WRITE) && !wr_last;
  assign wbeat_hs    = wbeat_valid && wbeat_ready;
  assign rbeat_hs    = rbeat_valid && rbeat_ready;

  always_comb begin
    state_nxt = state;
    op_nxt    = OP_NOP;
    unique case (state)
      IDLE: begin
        if (req_valid) begin
          state_nxt = ACT;
          op_nxt    = OP_ACT;
        end
      end
      ACT: state_nxt = RCD_WAIT;
      RCD_WAIT: begin
        if (cnt == '0) begin
          if (is_write) begin
            state_nxt = WRITE;
          end else begin
            state_nxt = READ;
            op_nxt    = OP_RD;
          end
        end
      end
      READ: begin
        // Next CAS only once the previous beat has been handed off
        if (rbeat_hs) begin
          if (bcnt == '0) begin
            state_nxt = PRE;
            op_nxt    = OP_PRE;
          end else begin
            op_nxt = OP_RD;
          end
        end
      end
      WRITE: begin
        if (wr_last) begin
          state_nxt = PRE;
          op_nxt    = OP_PRE;
        end else if (wbeat_hs) begin
          op_nxt = OP_WR;
        end
      end
      PRE: begin
        if (cnt == '0) begin
          state_nxt = IDLE;
        end
      end
      default: state_nxt = IDLE;
    endcase
  end

  // Pin values for the next cycle, a and d hold between commands
  always_comb begin
    cmd_nxt      = cmd;
    cmd_nxt.csn  = 1'b1;
    cmd_nxt.rasn = 1'b1;
    cmd_nxt.casn = 1'b1;
    cmd_nxt.wen  = 4'hf;
    case (op_nxt)
      OP_ACT: begin
        cmd_nxt.csn  = 1'b0;
        cmd_nxt.rasn = 1'b0;
        cmd_nxt.a    = req.row;
      end
      OP_RD: begin
        cmd_nxt.csn  = 1'b0;
        cmd_nxt.casn = 1'b0;
        cmd_nxt.a    = {1'b0, col};
      end
      OP_WR: begin
        cmd_nxt.csn  = 1'b0;
        cmd_nxt.casn = 1'b0;
        cmd_nxt.wen  = ~wbeat.strb;
        cmd_nxt.a    = {1'b0, col};
        cmd_nxt.d    = wbeat.data;
      end
      OP_PRE: begin
        cmd_nxt.csn  = 1'b0;
        cmd_nxt.rasn = 1'b0;
        cmd_nxt.a    = dram_a_pre_all;
      end
      default: ;
    endcase
  end

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      state       <= IDLE;
      cmd         <= dram_cmd_nop;
      cnt         <= '0;
      bcnt        <= '0;
      col         <= '0;
      is_write    <= 1'b0;
      wr_last     <= 1'b0;
      wr_done     <= 1'b0;
      rbeat_valid <= 1'b0;
    end else begin
      state   <= state_nxt;
      cmd     <= cmd_nxt;
      wr_done <= (state == WRITE) && wr_last;

      if (state == IDLE && req_valid) begin
        is_write <= req.write;
        col      <= req.col;
      end else if (op_nxt == OP_RD || op_nxt == OP_WR) begin
        col <= col + 1'b1;
      end

      // Shared timer for tRCD and tRP
      if (state == ACT) begin
        cnt <= CNT_W'(T_RCD - 1);
      end else if (op_nxt == OP_PRE) begin
        cnt <= CNT_W'(T_RP);
      end else if (cnt != '0) begin
        cnt <= cnt - 1'b1;
      end

      // Beats left after the one in flight
      if (state == IDLE && req_valid) begin
        bcnt <= req.len;
      end else if ((rbeat_hs || wbeat_hs) && bcnt != '0) begin
        bcnt <= bcnt - 1'b1;
      end

      if (wbeat_hs && bcnt == '0) begin
        wr_last <= 1'b1;
      end else if (state == PRE) begin
        wr_last <= 1'b0;
      end

      if (state == READ && rsp.valid) begin
        rbeat_valid <= 1'b1;
      end else if (rbeat_hs) begin
        rbeat_valid <= 1'b0;
      end
    end
  end

  always_ff @(posedge clk) begin
    if (state == READ && rsp.valid) begin
      rbeat_data <= rsp.q;
    end
  end

endmodule

`default_nettype wire

//--- rtl/axi_slave_port.sv
`timescale 1ns/1ns
`default_nettype none

module axi_slave_port
  import axi_pkg::*, dram_pkg::*;
(
  input  logic      clk,
  input  logic      rstn,
  input  axi_ax_t   aw,
  input  logic      aw_valid,
  output logic      aw_ready,
  input  axi_w_t    w,
  input  logic      w_valid,
  output logic      w_ready,
  input  axi_ax_t   ar,
  input  logic      ar_valid,
  output logic      ar_ready,
  output axi_r_t    r,
  output logic      r_valid,
  input  logic      r_ready,
  output axi_b_t    b,
  output logic      b_valid,
  input  logic      b_ready,
  output mem_req_t  req,
  output logic      req_valid,
  input  logic      req_ready,
  output axi_w_t    wbeat,
  output logic      wbeat_valid,
  input  logic      wbeat_ready,
  input  axi_data_t rbeat_data,
  input  logic      rbeat_valid,
  output logic      rbeat_ready,
  input  logic      wr_done
);

  typedef enum logic [1:0] {
    PS_IDLE,
    PS_WR,
    PS_RD,
    PS_B
  } port_state_e;

  port_state_e pstate;
  axi_len_t    rcnt;
  logic        aw_hs;
  logic        ar_hs;
  logic        rbeat_hs;
  logic        r_hs;

  function automatic mem_req_t to_req(input logic write, input axi_ax_t ax);
    mem_req_t m;
    m.write = write;
    m.id    = ax.id;
    m.row   = row_of(ax.addr);
    m.col   = col_of(ax.addr);
    m.len   = ax.len;
    return m;
  endfunction

  // New transactions only while the controller sits in IDLE, writes win ties
  assign aw_ready = (pstate == PS_IDLE) && req_ready;
  assign ar_ready = (pstate == PS_IDLE) && req_ready && !aw_valid;
  assign aw_hs    = aw_valid && aw_ready;
  assign ar_hs    = ar_valid && ar_ready;

  // W goes straight through to the controller
  assign wbeat       = w;
  assign wbeat_valid = (pstate == PS_WR) && w_valid;
  assign w_ready     = (pstate == PS_WR) && wbeat_ready;

  // R register takes a beat when empty or draining
  assign rbeat_ready = (pstate == PS_RD) && (!r_valid || r_ready);
  assign rbeat_hs    = rbeat_valid && rbeat_ready;
  assign r_hs        = r_valid && r_ready;

  assign b_valid = (pstate == PS_B);
  assign b       = '{id: req.id, resp: axi_resp_okay};

  always_ff @(posedge clk or negedge rstn) begin
    if (!rstn) begin
      pstate    <= PS_IDLE;
      req_valid <= 1'b0;
      r_valid   <= 1'b0;
      rcnt      <= '0;
    end else begin
      if (aw_hs || ar_hs) begin
        req_valid <= 1'b1;
      end else if (req_ready) begin
        req_valid <= 1'b0;
      end

      unique case (pstate)
        PS_IDLE: begin
          if (aw_hs) begin
            pstate <= PS_WR;
          end else if (ar_hs) begin
            pstate <= PS_RD;
          end
        end
        PS_WR: begin
          if (wr_done) begin
            pstate <= PS_B;
          end
        end
        PS_RD: begin
          if (r_hs && r.last) begin
            pstate <= PS_IDLE;
          end
        end
        PS_B: begin
          if (b_ready) begin
            pstate <= PS_IDLE;
          end
        end
        default: pstate <= PS_IDLE;
      endcase

      // Beats loaded into R so far, sets RLAST
      if (ar_hs) begin
        rcnt <= '0;
      end else if (rbeat_hs) begin
        rcnt <= rcnt + 1'b1;
      end

      if (rbeat_hs) begin
        r_valid <= 1'b1;
      end else if (r_hs) begin
        r_valid <= 1'b0;
      end
    end
  end

  // Request and R payload
  always_ff @(posedge clk) begin
    if (aw_hs) begin
      req <= to_req(1'b1, aw);
    end else if (ar_hs) begin
      req <= to_req(1'b0, ar);
    end
    if (rbeat_hs) begin
      r <= '{id: req.id, data: rbeat_data, resp: axi_resp_okay, last: (rcnt == req.len)};
    end
  end

endmodule

`default_nettype wire

//--- rtl/dram_pkg.sv
`default_nettype none

package dram_pkg;

  typedef logic [10:0] dram_row_t;
  typedef logic [9:0]  dram_col_t;

  // DRAM pins, all strobes active low
  // A RAS strobe opens the row on a when no row is open and closes it otherwise,
  // precharge also sets a[10] as in SDR precharge-all
  typedef struct packed {
    logic        csn;
    logic        rasn;
    logic        casn;
    logic [3:0]  wen;
    logic [10:0] a;
    logic [31:0] d;
  } dram_cmd_t;

  // Read data, valid for one cycle after the CAS latency
  typedef struct packed {
    logic [31:0] q;
    logic        valid;
  } dram_rsp_t;

  // One transaction from the slave port to the controller
  typedef struct packed {
    logic      write;
    logic [3:0] id;
    dram_row_t row;
    dram_col_t col;
    logic [3:0] len;
  } mem_req_t;

  typedef enum logic [5:0] {
    IDLE     = 6'b000001,
    ACT      = 6'b000010,
    RCD_WAIT = 6'b000100,
    READ     = 6'b001000,
    WRITE    = 6'b010000,
    PRE      = 6'b100000
  } ctrl_state_e;

  // Command placed on the pins in the following cycle
  typedef enum logic [2:0] {
    OP_NOP,
    OP_ACT,
    OP_RD,
    OP_WR,
    OP_PRE
  } dram_op_e;

  localparam logic [10:0] dram_a_pre_all = 11'h400;

  localparam dram_cmd_t dram_cmd_nop = '{
    csn: 1'b1, rasn: 1'b1, casn: 1'b1, wen: 4'hf, a: 11'h000, d: 32'h0
  };

  function automatic dram_row_t row_of(input logic [31:0] addr);
    return addr[22:12];
  endfunction

  function automatic dram_col_t col_of(input logic [31:0] addr);
    return addr[11:2];
  endfunction

endpackage

`default_nettype wire

//--- rtl/axi_pkg.sv
`default_nettype none

package axi_pkg;

  typedef logic [3:0]  axi_id_t;
  typedef logic [31:0] axi_addr_t;
  // Beats in a burst are len + 1
  typedef logic [3:0]  axi_len_t;
  typedef logic [31:0] axi_data_t;
  typedef logic [3:0]  axi_strb_t;

  // Only response the port ever returns
  localparam logic [1:0] axi_resp_okay = 2'b00;

  // Address channel payload, same layout for AW and AR
  typedef struct packed {
    axi_id_t   id;
    axi_addr_t addr;
    axi_len_t  len;
  } axi_ax_t;

  // Write beat
  typedef struct packed {
    axi_data_t data;
    axi_strb_t strb;
    logic      last;
  } axi_w_t;

  // Read beat
  typedef struct packed {
    axi_id_t    id;
    axi_data_t  data;
    logic [1:0] resp;
    logic       last;
  } axi_r_t;

  // Write response
  typedef struct packed {
    axi_id_t    id;
    logic [1:0] resp;
  } axi_b_t;

endpackage

`default_nettype wire
